//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - source
    files:
      - source/isaPkg.sv
      - source/wbPkg.sv
      - source/ctrlUnit.sv
      - source/aluCtrl.sv
      - source/alu.sv
      - source/regFile.sv
      - source/mipsCore.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/mips_checker.sv
      - sim/tbMips.sv

//--- sim/mips_checker.sv
`timescale 1ns/1ps

module mips_checker (
    input logic         iClk,
    input logic         iRst_n,
    input wbPkg::wbReqS wbReq,
    input wbPkg::wbRspS wbRsp
);

    int failCount = 0;  // Assertion failures so far

    stbNeedsCyc: assert property (@(posedge iClk) disable iff (!iRst_n)
        wbReq.stb |-> wbReq.cyc)
        else begin
            failCount++;
            $error("Wishbone stb high without cyc");
        end

    // Request held until ack
    reqStable: assert property (@(posedge iClk) disable iff (!iRst_n)
        (wbReq.stb && !wbRsp.ack) |=>
            ($stable(wbReq.adr) && $stable(wbReq.we) && $stable(wbReq.dat)))
        else begin
            failCount++;
            $error("Wishbone request changed before ack");
        end

    quietInReset: assert property (@(posedge iClk)
        !iRst_n |-> (!wbReq.cyc && !wbReq.stb))
        else begin
            failCount++;
            $error("Wishbone request during reset");
        end

    wordAligned: assert property (@(posedge iClk) disable iff (!iRst_n)
        wbReq.cyc |-> (wbReq.adr[1:0] == 2'b00))
        else begin
            failCount++;
            $error("Wishbone address not word aligned");
        end

endmodule

bind mipsCore mips_checker uChecker (
    .iClk   (iClk),
    .iRst_n (iRst_n),
    .wbReq  (wbReq),
    .wbRsp  (wbRsp)
);

//--- sim/program_golden.txt
# M <byte address> <word>   memory image, hex
# W <byte address> <word>   expected store, in order, hex
M 00000000 2001FFFB
M 00000004 34020003
M 00000008 0022182A
M 0000000C 2C240003
M 00000010 AC030100
M 00000014 AC040104
M 00000018 3C051234
M 0000001C 00013043
M 00000020 00A63820
M 00000024 AC070108
M 00000028 8C080200
M 0000002C 00484804
M 00000030 11280001
M 00000034 AC09010C
M 00000038 15280001
M 0000003C AC0001F0
M 00000040 0C000014
M 00000044 AC1F0110
M 00000048 08000018
M 0000004C AC0001F4
M 00000050 AC000114
M 00000054 03E00008
M 00000060 340A0070
M 00000064 01405809
M 00000068 AC0001F8
M 00000070 AC0B0118
M 00000074 8C0C0108
M 00000078 01806827
M 0000007C AC0D011C
M 00000080 08000020
M 00000200 0000000F
W 00000100 00000001
W 00000104 00000000
W 00000108 1233FFFD
W 0000010C 00000078
W 00000114 00000000
W 00000110 00000044
W 00000118 00000068
W 0000011C EDCC0002

//--- sim/tbMips.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tbMips;

    localparam int MEM_WORDS = 1024;

    logic         iClk;
    logic         iRst_n;
    wbPkg::wbReqS wbReq;
    wbPkg::wbRspS wbRsp;

    logic [31:0] mem [MEM_WORDS];
    logic [`CORE_ADDR_W-1:0] expAddrQ [$];
    logic [31:0]             expDataQ [$];

    logic [15:0] lfsr;
    logic        busy;
    logic [1:0]  waitCnt;
    logic        firstSeen;
    logic        loaded;
    int          instrCount;

    mipsCore u_dut (
        .iClk   (iClk),
        .iRst_n (iRst_n),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp)
    );

    initial begin
        iClk = 1'b0;
        forever #50 iClk = ~iClk;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Two bits, one LFSR step each
    task automatic drawWait(output logic [1:0] w);
        w[0] = lfsr[0];
        lfsr = lfsrNext(lfsr);
        w[1] = lfsr[0];
        lfsr = lfsrNext(lfsr);
    endtask

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic checkAddr(input logic [`CORE_ADDR_W-1:0] got,
                             input logic [`CORE_ADDR_W-1:0] exp);
        if (got !== exp) begin
            failRun($sformatf("FAIL t=%0t wbReq.adr got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic checkData(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("FAIL t=%0t wbReq.dat got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic checkWe(input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("FAIL t=%0t wbReq.we got %b expected %b", $time, got, exp));
        end
    endtask

    // Serve the request that is on the bus now
    task automatic respond();
        wbRsp.ack <= 1'b1;
        busy      <= 1'b0;
        if (wbReq.we) begin
            if (expAddrQ.size() == 0) begin
                failRun($sformatf("Store to %h at %0t with no store expected", wbReq.adr, $time));
            end else begin
                checkAddr(wbReq.adr, expAddrQ.pop_front());
                checkData(wbReq.dat, expDataQ.pop_front());
            end
            mem[wbReq.adr[11:2]] = wbReq.dat;
        end else begin
            wbRsp.dat <= mem[wbReq.adr[11:2]];
        end
    endtask

    initial begin
        int          fd;
        string       line;
        logic [31:0] a;
        logic [31:0] d;

        iRst_n     = 1'b0;
        wbRsp      = '0;
        lfsr       = 16'd4292;
        busy       = 1'b0;
        waitCnt    = '0;
        firstSeen  = 1'b0;
        loaded     = 1'b0;
        instrCount = 0;

        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[15:0] ^ 16'hA5A5, ~i[15:0]};  // Unused words are recognizable
        end

        fd = $fopen("sim/program_golden.txt", "r");
        if (fd == 0)
            failRun("Cannot open sim/program_golden.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "M %h %h", a, d) == 2) begin
                mem[a[11:2]] = d;
                instrCount++;
            end else if ($sscanf(line, "W %h %h", a, d) == 2) begin
                expAddrQ.push_back(a);
                expDataQ.push_back(d);
            end
        end
        $fclose(fd);
        if (expAddrQ.size() == 0)
            failRun("Golden file holds no expected stores");
        loaded = 1'b1;

        repeat (16) @(posedge iClk);
        iRst_n <= 1'b1;

        wait (expAddrQ.size() == 0);
        repeat (4) @(posedge iClk);
        $display("SIMULATION PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded);
        #((instrCount * 12 + 200) * 100);
        failRun("Timeout: the expected stores did not all arrive in time");
    end

    // Bound protocol checker counts its assertion failures
    initial begin
        wait (u_dut.uChecker.failCount != 0);
        failRun("A Wishbone protocol assertion failed");
    end

    // Wishbone slave memory with random wait states
    always @(posedge iClk) begin
        logic [1:0] w;
        if (iRst_n) begin
            if (wbRsp.ack) begin
                wbRsp.ack <= 1'b0;
            end else if (wbReq.cyc && wbReq.stb) begin
                if (!firstSeen) begin
                    firstSeen = 1'b1;
                    checkWe(wbReq.we, 1'b0);    // First cycle is the reset fetch
                    checkAddr(wbReq.adr, `CORE_RESET_PC);
                end
                if (!busy) begin
                    drawWait(w);
                    if (w == 2'd0) begin
                        respond();
                    end else begin
                        busy    <= 1'b1;
                        waitCnt <= w - 2'd1;
                    end
                end else if (waitCnt == 2'd0) begin
                    respond();
                end else begin
                    waitCnt <= waitCnt - 2'd1;
                end
            end
        end
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [31:0]   a,
    input  logic [31:0]   b,
    input  isaPkg::aluOpE aluOp,
    input  logic          signedOp,
    output logic [31:0]   result,
    output logic          zero
);

    logic [4:0] shAmt;
    logic       lessThan;

    assign shAmt = a[4:0];  // Shift source is always b

    // Set-less-than, signed or unsigned
    assign lessThan = signedOp ? ($signed(a) < $signed(b)) : (a < b);

    always_comb begin
        case (aluOp)
            isaPkg::ALU_ADD: result = a + b;
            isaPkg::ALU_SUB: result = a - b;
            isaPkg::ALU_AND: result = a & b;
            isaPkg::ALU_OR:  result = a | b;
            isaPkg::ALU_XOR: result = a ^ b;
            isaPkg::ALU_NOR: result = ~(a | b);
            isaPkg::ALU_SLL: result = b << shAmt;
            isaPkg::ALU_SRL: result = b >> shAmt;
            isaPkg::ALU_SRA: result = $signed(b) >>> shAmt;
            isaPkg::ALU_LT:  result = {31'b0, lessThan};
            isaPkg::ALU_LUI: result = {b[15:0], 16'h0000};
            default:         result = '0;
        endcase
    end

    assign zero = (result == 32'h0);   // beq and bne decide on this

endmodule

//--- source/aluCtrl.sv
`timescale 1ns/1ps

module aluCtrl (
    input  isaPkg::aluClassE aluClass,
    input  isaPkg::instrU    instr,
    output isaPkg::aluCtrlS  aluCtl
);

    always_comb begin
        aluCtl = '0;

        case (aluClass)
            isaPkg::CLS_MEM:    aluCtl.aluOp = isaPkg::ALU_ADD;
            isaPkg::CLS_BRANCH: aluCtl.aluOp = isaPkg::ALU_SUB;

            isaPkg::CLS_FUNCT: begin
                case (instr.r.funct)
                    isaPkg::FN_ADD:  begin
                        aluCtl.aluOp    = isaPkg::ALU_ADD;
                        aluCtl.signedOp = 1'b1;
                    end
                    isaPkg::FN_ADDU: aluCtl.aluOp = isaPkg::ALU_ADD;
                    isaPkg::FN_SUB:  begin
                        aluCtl.aluOp    = isaPkg::ALU_SUB;
                        aluCtl.signedOp = 1'b1;
                    end
                    isaPkg::FN_SUBU: aluCtl.aluOp = isaPkg::ALU_SUB;
                    isaPkg::FN_AND:  aluCtl.aluOp = isaPkg::ALU_AND;
                    isaPkg::FN_OR:   aluCtl.aluOp = isaPkg::ALU_OR;
                    isaPkg::FN_XOR:  aluCtl.aluOp = isaPkg::ALU_XOR;
                    isaPkg::FN_NOR:  aluCtl.aluOp = isaPkg::ALU_NOR;
                    isaPkg::FN_SLLV: aluCtl.aluOp = isaPkg::ALU_SLL;
                    isaPkg::FN_SRLV: aluCtl.aluOp = isaPkg::ALU_SRL;
                    isaPkg::FN_SRAV: aluCtl.aluOp = isaPkg::ALU_SRA;
                    isaPkg::FN_SLL,
                    isaPkg::FN_SRL,
                    isaPkg::FN_SRA:  begin
                        aluCtl.useShamt = 1'b1;
                        // Low funct bits match the variable forms
                        aluCtl.aluOp = (instr.r.funct == isaPkg::FN_SLL) ? isaPkg::ALU_SLL :
                                       (instr.r.funct == isaPkg::FN_SRL) ? isaPkg::ALU_SRL :
                                                                           isaPkg::ALU_SRA;
                    end
                    isaPkg::FN_SLT:  begin
                        aluCtl.aluOp    = isaPkg::ALU_LT;
                        aluCtl.signedOp = 1'b1;
                    end
                    isaPkg::FN_JR:   aluCtl.jumpReg = 1'b1;
                    isaPkg::FN_JALR: begin
                        aluCtl.jumpReg     = 1'b1;
                        aluCtl.jumpRegLink = 1'b1;
                    end
                    default: ;
                endcase
            end

            isaPkg::CLS_OPCODE: begin
                case (instr.i.opcode)
                    isaPkg::OP_ADDI:  begin
                        aluCtl.aluOp    = isaPkg::ALU_ADD;
                        aluCtl.signedOp = 1'b1;
                    end
                    isaPkg::OP_ADDIU: aluCtl.aluOp = isaPkg::ALU_ADD;
                    isaPkg::OP_ANDI:  aluCtl.aluOp = isaPkg::ALU_AND;
                    isaPkg::OP_ORI:   aluCtl.aluOp = isaPkg::ALU_OR;
                    isaPkg::OP_SLTI:  begin
                        aluCtl.aluOp    = isaPkg::ALU_LT;
                        aluCtl.signedOp = 1'b1;
                    end
                    isaPkg::OP_SLTIU: aluCtl.aluOp = isaPkg::ALU_LT;
                    isaPkg::OP_LUI:   aluCtl.aluOp = isaPkg::ALU_LUI;
                    default: ;
                endcase
            end

            default: ;
        endcase
    end

endmodule

//--- source/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Address of the first instruction fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// Architectural register count
`define CORE_NUM_REGS 32

// Wishbone address width
`define CORE_ADDR_W 32

`endif

//--- source/ctrlUnit.sv
`timescale 1ns/1ps

module ctrlUnit (
    input  isaPkg::instrU instr,
    output isaPkg::ctrlS  ctrl
);

    always_comb begin
        ctrl = '0;  // Unknown opcodes fall through as a no-op

        case (instr.r.opcode)
            isaPkg::OP_RTYPE: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluClass = isaPkg::CLS_FUNCT;
            end

            isaPkg::OP_ADDI,
            isaPkg::OP_ADDIU,
            isaPkg::OP_SLTI,
            isaPkg::OP_SLTIU,
            isaPkg::OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluClass  = isaPkg::CLS_OPCODE;
            end

            // Logical immediates are zero extended
            isaPkg::OP_ANDI,
            isaPkg::OP_ORI: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrcImm  = 1'b1;
                ctrl.aluClass   = isaPkg::CLS_OPCODE;
                ctrl.zeroExtImm = 1'b1;
            end

            isaPkg::OP_LW: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluClass  = isaPkg::CLS_MEM;
            end

            isaPkg::OP_SW: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluClass  = isaPkg::CLS_MEM;
            end

            isaPkg::OP_BEQ,
            isaPkg::OP_BNE: begin
                ctrl.branch   = 1'b1;
                ctrl.branchEq = (instr.r.opcode == isaPkg::OP_BEQ);
                ctrl.aluClass = isaPkg::CLS_BRANCH;
            end

            isaPkg::OP_J: begin
                ctrl.jump = 1'b1;
            end

            isaPkg::OP_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.jumpLink = 1'b1;
                ctrl.regWrite = 1'b1;   // Link into r31
            end

            default: ;
        endcase
    end

endmodule

//--- source/isaPkg.sv
package isaPkg;

    // Primary opcodes, R-type class at zero
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LT, ALU_LUI
    } aluOpE;

    // How aluCtrl picks the operation
    typedef enum logic [1:0] {
        CLS_MEM    = 2'b00,     // Address add for lw and sw
        CLS_BRANCH = 2'b01,     // Subtract for beq and bne
        CLS_FUNCT  = 2'b10,
        CLS_OPCODE = 2'b11
    } aluClassE;

    typedef struct packed {
        opcodeE     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functE      funct;
    } rViewS;

    typedef struct packed {
        opcodeE      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iViewS;

    typedef struct packed {
        opcodeE      opcode;
        logic [25:0] target;
    } jViewS;

    // One instruction word, three field layouts
    typedef union packed {
        rViewS r;
        iViewS i;
        jViewS j;
    } instrU;

    typedef struct packed {
        logic     regDst;       // Write rd instead of rt
        logic     regWrite;
        logic     memToReg;
        logic     memRead;
        logic     memWrite;
        logic     aluSrcImm;
        aluClassE aluClass;
        logic     branch;
        logic     branchEq;     // Taken on equal, else on not equal
        logic     jump;
        logic     jumpLink;
        logic     zeroExtImm;   // andi and ori
    } ctrlS;

    typedef struct packed {
        aluOpE aluOp;
        logic  signedOp;
        logic  useShamt;        // Shift amount from the shamt field
        logic  jumpReg;
        logic  jumpRegLink;
    } aluCtrlS;

endpackage

//--- source/mipsCore.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module mipsCore (
    input  logic         iClk,
    input  logic         iRst_n,
    output wbPkg::wbReqS wbReq,
    input  wbPkg::wbRspS wbRsp
);

    typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEM, WRITEBACK} stateE;

    stateE           state;
    logic [31:0]     pc;
    logic [31:0]     pcPlus4;
    logic [31:0]     pcNextQ;       // Next PC, held until the instruction retires
    isaPkg::instrU   instr;
    logic [31:0]     rsQ;
    logic [31:0]     rtQ;
    logic [31:0]     aluOutQ;
    logic [31:0]     memDataQ;

    isaPkg::ctrlS    ctrl;
    isaPkg::aluCtrlS aluCtl;

    logic [31:0]     rdDataA;
    logic [31:0]     rdDataB;
    logic [4:0]      wrAddr;
    logic [31:0]     wrData;
    logic            wrEn;

    logic [31:0]     immExt;
    logic [31:0]     branchTarget;
    logic [31:0]     jumpTarget;
    logic [31:0]     nextPc;
    logic [31:0]     aluA;
    logic [31:0]     aluB;
    logic [31:0]     aluResult;
    logic            aluZero;
    logic            branchTaken;
    logic            writesReg;
    logic            linkWrite;

    // Builds a new bus request
    function automatic wbPkg::wbReqS busReq(
        input logic [`CORE_ADDR_W-1:0] addr,
        input logic                    we,
        input logic [31:0]             data
    );
        wbPkg::wbReqS req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = addr;
        req.dat = data;
        return req;
    endfunction

    ctrlUnit uCtrlUnit (
        .instr (instr),
        .ctrl  (ctrl)
    );

    aluCtrl uAluCtrl (
        .aluClass (ctrl.aluClass),
        .instr    (instr),
        .aluCtl   (aluCtl)
    );

    alu uAlu (
        .a        (aluA),
        .b        (aluB),
        .aluOp    (aluCtl.aluOp),
        .signedOp (aluCtl.signedOp),
        .result   (aluResult),
        .zero     (aluZero)
    );

    regFile uRegFile (
        .iClk    (iClk),
        .iRst_n  (iRst_n),
        .rdAddrA (instr.r.rs),
        .rdAddrB (instr.r.rt),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .wrEn    (wrEn),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    assign pcPlus4 = pc + 32'd4;
    assign immExt  = ctrl.zeroExtImm ? {16'h0000, instr.i.imm}
                                     : {{16{instr.i.imm[15]}}, instr.i.imm};

    // Shamt shifts put the amount on a, rt stays the shift source on b
    assign aluA = aluCtl.useShamt ? {27'b0, instr.r.shamt} : rsQ;
    assign aluB = ctrl.aluSrcImm ? immExt : rtQ;

    assign branchTarget = pcPlus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr.j.target, 2'b00};
    assign branchTaken  = ctrl.branch && (aluZero == ctrl.branchEq);

    always_comb begin
        if (aluCtl.jumpReg)
            nextPc = rsQ;
        else if (ctrl.jump)
            nextPc = jumpTarget;
        else if (branchTaken)
            nextPc = branchTarget;
        else
            nextPc = pcPlus4;
    end

    // jr decodes as R-type but writes nothing
    assign writesReg = ctrl.regWrite && !(aluCtl.jumpReg && !aluCtl.jumpRegLink);
    assign linkWrite = ctrl.jumpLink || aluCtl.jumpRegLink;

    assign wrEn   = (state == WRITEBACK);
    assign wrAddr = ctrl.jumpLink ? 5'(`CORE_NUM_REGS - 1) :
                    ctrl.regDst   ? instr.r.rd : instr.r.rt;
    assign wrData = linkWrite     ? pcPlus4  :
                    ctrl.memToReg ? memDataQ : aluOutQ;

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            state <= FETCH;
            pc    <= `CORE_RESET_PC;
            wbReq <= '0;
        end else begin
            case (state)
                FETCH: begin
                    if (!wbReq.cyc) begin
                        wbReq <= busReq(pc, 1'b0, 32'h0);   // After reset or a store
                    end else if (wbRsp.ack) begin
                        wbReq.cyc <= 1'b0;
                        wbReq.stb <= 1'b0;
                        state     <= DECODE;
                    end
                end

                DECODE: state <= EXECUTE;

                EXECUTE: begin
                    if (ctrl.memRead || ctrl.memWrite) begin
                        wbReq <= busReq(aluResult, ctrl.memWrite, rtQ);
                        state <= MEM;
                    end else if (writesReg) begin
                        state <= WRITEBACK;
                    end else begin
                        pc    <= nextPc;    // Branches, j and jr retire here
                        wbReq <= busReq(nextPc, 1'b0, 32'h0);
                        state <= FETCH;
                    end
                end

                MEM: begin
                    if (wbRsp.ack) begin
                        wbReq.cyc <= 1'b0;
                        wbReq.stb <= 1'b0;
                        wbReq.we  <= 1'b0;
                        if (ctrl.memRead) begin
                            state <= WRITEBACK;
                        end else begin
                            pc    <= pcNextQ;
                            state <= FETCH;     // Fetch request follows one idle cycle
                        end
                    end
                end

                WRITEBACK: begin
                    pc    <= pcNextQ;
                    wbReq <= busReq(pcNextQ, 1'b0, 32'h0);
                    state <= FETCH;
                end

                default: state <= FETCH;
            endcase
        end
    end

    // Datapath latches
    always_ff @(posedge iClk) begin
        if (state == FETCH && wbReq.cyc && wbRsp.ack)
            instr <= wbRsp.dat;
        if (state == DECODE) begin
            rsQ <= rdDataA;
            rtQ <= rdDataB;
        end
        if (state == EXECUTE) begin
            aluOutQ <= aluResult;
            pcNextQ <= nextPc;
        end
        if (state == MEM && wbRsp.ack)
            memDataQ <= wbRsp.dat;
    end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module regFile (
    input  logic        iClk,
    input  logic        iRst_n,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData,
    input  logic        wrEn,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB
);

    logic [31:0] regs [`CORE_NUM_REGS];

    always_ff @(posedge iClk or negedge iRst_n) begin
        if (!iRst_n) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr] <= wrData;     // r0 stays zero
        end
    end

    // Combinational reads
    assign rdDataA = (rdAddrA == 5'd0) ? 32'h0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == 5'd0) ? 32'h0 : regs[rdAddrB];

endmodule

//--- source/wbPkg.sv
`include "core_settings.svh"

package wbPkg;

    // Master to slave
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`CORE_ADDR_W-1:0] adr;
        logic [31:0]             dat;   // Write data
    } wbReqS;

    // Slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;   // Read data, valid with ack
    } wbRspS;

endpackage

//--- vlog.f
+incdir+source
source/isaPkg.sv
source/wbPkg.sv
source/ctrlUnit.sv
source/aluCtrl.sv
source/alu.sv
source/regFile.sv
source/mipsCore.sv
sim/mips_checker.sv
sim/tbMips.sv
